//--- hdl/acq_data_pkg.sv
// --------------------------------------------------------------------
// Sample data definitions
// --------------------------------------------------------------------
// One word holds one sign bit per antenna, taken on the same
// sample clock edge. Bit n belongs to antenna n.
package acq_data_pkg;

   // Number of antennas, and so the width of one captured word
   localparam int SAMPLE_WIDTH = 24;

   // One captured word, passed unchanged through
   // the buffer to the DRAM writer
   typedef logic [SAMPLE_WIDTH-1:0] sample_t;

   // The buffer, the capture and the reader all carry this type.
   // Widening the array only needs SAMPLE_WIDTH to change here

   // Word order in the output stream follows capture order
   // inside a block. Blocks leave in the order they completed,
   // except for blocks that were dropped on overflow

   // No framing or header word is added. Block boundaries
   // are marked only by the block start strobe on the reader side

endpackage

//--- hdl/acq_ctrl_pkg.sv
// --------------------------------------------------------------------
// Control definitions for the acquisition front end
// --------------------------------------------------------------------
package acq_ctrl_pkg;

   // log2 of the words per block
   // 16 words per block, two blocks in the ping-pong buffer
   localparam int BLOCK_BITS_DEFAULT = 4;

   // Read side sequencer states
   typedef enum logic {
      IDLE   = 1'b0,   // Waiting for a completed block
      STREAM = 1'b1    // Sweeping the offsets of one half
   } reader_state_t;

   // The reader leaves STREAM on its own after the last offset.
   // A block that completes while it is in STREAM is not queued,
   // it raises the sticky overflow and is lost

   // Capture side has no encoded state
   // It only keeps a capturing flag, the half select and an offset

endpackage

//--- hdl/buffer_write_if.sv
// Write port of the ping-pong buffer, in the sample clock domain
interface buffer_write_if #(
   parameter int BLOCK_BITS = acq_ctrl_pkg::BLOCK_BITS_DEFAULT
) (
   input logic write_clock   // Sample clock
);
   import acq_data_pkg::*;

   logic                write_enable;    // One word per edge while high
   logic [BLOCK_BITS:0] write_address;   // Top bit is the half, rest the offset
   sample_t             write_data;

   // Capture side drives everything but the clock
   modport writer (
      input  write_clock,
      output write_enable, write_address, write_data
   );

   // Buffer side only listens
   modport ram (
      input write_clock, write_enable, write_address, write_data
   );
endinterface

//--- hdl/block_buffer.sv
// Two-block dual-clock buffer
// Written from the sample domain, read back on read_clock_i
module block_buffer #(
   parameter int BLOCK_BITS = acq_ctrl_pkg::BLOCK_BITS_DEFAULT
) (
   buffer_write_if.ram           ram,             // Write port, carries its own clock
   input  logic                  read_clock_i,
   input  logic [BLOCK_BITS:0]   read_address_i,  // Half bit and offset
   output acq_data_pkg::sample_t read_data_o      // Word of last sampled address
);
   import acq_data_pkg::*;

   // Two halves of 2^BLOCK_BITS words each
   localparam int DEPTH = 2 ** (BLOCK_BITS + 1);

   // ------------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------------
   // Plain array so the tool maps it to whatever block RAM it has.
   // Contents are undefined at start up and are never read
   // before the capture has filled a half
   sample_t mem [DEPTH];

   // ------------------------------------------------------------------
   // Write port, sample clock domain
   // ------------------------------------------------------------------
   always_ff @(posedge ram.write_clock) begin
      if (ram.write_enable) begin
         mem[ram.write_address] <= ram.write_data;   // One word per enabled edge
      end
   end

   // ------------------------------------------------------------------
   // Read port, read clock domain
   // ------------------------------------------------------------------
   // Registered read, one cycle from address to data.
   // The reader only sweeps a half once its done toggle has crossed,
   // and the capture is then busy in the other half.
   // So one address is never written and read at the same time
   always_ff @(posedge read_clock_i) begin
      read_data_o <= mem[read_address_i];   // Output register, no reset
   end

   // Address layout seen from both sides
   //   [BLOCK_BITS]     half select, alternates block by block
   //   [BLOCK_BITS-1:0] word offset inside the block
   // Capture fills offsets upward from 0
   // and the reader sweeps them in the same order,
   // so words leave in the order they arrived

   // No read enable. The reader presents an address every cycle
   // and flags the useful ones with its own valid pipeline

endmodule

//--- hdl/sample_capture.sv
// Write side block packer, runs entirely on the sample clock
// Fills one half of the buffer per block and signals completion
// to the read side with a toggle
module sample_capture #(
   parameter int BLOCK_BITS = acq_ctrl_pkg::BLOCK_BITS_DEFAULT
) (
   buffer_write_if.writer        wr,             // Buffer write port and sample clock
   input  logic                  rst_i,          // Read domain reset
   input  logic                  acq_en_i,       // Read domain capture enable
   input  acq_data_pkg::sample_t sample_i,       // One antenna word per sample clock
   output logic                  done_toggle_o,  // Flips once per completed block
   output logic                  done_half_o     // Half of the block just completed
);
   import acq_data_pkg::*;

   typedef logic [BLOCK_BITS-1:0] offset_t;   // Word offset inside a block

   localparam offset_t LAST_OFFSET = '1;                    // Final word of a block
   localparam offset_t PRE_LAST    = LAST_OFFSET - 1'b1;    // One word before it

   logic    rst_meta;     // Reset synchroniser, first stage
   logic    rst_sync;     // Reset in the sample domain
   logic    en_meta;      // Enable synchroniser, first stage
   logic    en_sync;      // Enable in the sample domain
   sample_t sample_q;     // Input register
   logic    capturing;    // Writing the current block
   logic    half;         // Half being filled
   offset_t offset;       // Next offset to write

   // ------------------------------------------------------------------
   // Crossing into the sample domain
   // ------------------------------------------------------------------
   // Reset goes through two flops and then acts synchronously
   always_ff @(posedge wr.write_clock) begin
      rst_meta <= rst_i;
      rst_sync <= rst_meta;
   end

   // Enable is a slow level, two flops are enough
   always_ff @(posedge wr.write_clock) begin
      if (rst_sync) begin
         en_meta <= 1'b0;
         en_sync <= 1'b0;
      end else begin
         en_meta <= acq_en_i;
         en_sync <= en_meta;
      end
   end

   // Every sample is registered, used or not
   always_ff @(posedge wr.write_clock) begin
      sample_q <= sample_i;
   end

   // ------------------------------------------------------------------
   // Block sequencing
   // ------------------------------------------------------------------
   // Offset stays at 0 while idle, so a start is always on a boundary.
   // The enable is only looked at when idle or on the last word
   always_ff @(posedge wr.write_clock) begin
      if (rst_sync) begin
         capturing     <= 1'b0;
         half          <= 1'b0;
         offset        <= '0;
         done_toggle_o <= 1'b0;
         done_half_o   <= 1'b0;
      end else if (capturing) begin
         offset <= offset + 1'b1;   // Wraps to 0 after the last word
         // Half is posted one word early so that it has settled
         // before the toggle edge the reader samples it on
         if (offset == PRE_LAST) begin
            done_half_o <= half;
         end
         if (offset == LAST_OFFSET) begin
            done_toggle_o <= ~done_toggle_o;   // Block complete
            half          <= ~half;            // Ping-pong
            capturing     <= en_sync;          // Stop only here
         end
      end else if (en_sync) begin
         capturing <= 1'b1;   // Next half from offset 0
      end
   end

   // ------------------------------------------------------------------
   // Buffer write port
   // ------------------------------------------------------------------
   // Word registered on one edge is written on the next
   assign wr.write_enable  = capturing;
   assign wr.write_address = {half, offset};
   assign wr.write_data    = sample_q;

endmodule

//--- hdl/block_reader.sv
// Read side block streamer
// Waits for a completed half, then sweeps it out one word per cycle
module block_reader #(
   parameter int BLOCK_BITS = acq_ctrl_pkg::BLOCK_BITS_DEFAULT
) (
   input  logic                  read_clock_i,
   input  logic                  rst_i,
   input  logic                  done_toggle_i,   // From the sample domain
   input  logic                  done_half_i,     // Stable around each toggle
   output logic [BLOCK_BITS:0]   read_address_o,  // To the buffer
   input  acq_data_pkg::sample_t read_data_i,     // From the buffer, one cycle late
   output acq_data_pkg::sample_t data_o,          // Toward the DRAM writer
   output logic                  data_valid_o,
   output logic                  block_start_o,   // With the first word of a block
   output logic                  overflow_o       // Sticky, a block was dropped
);
   import acq_ctrl_pkg::*;

   typedef logic [BLOCK_BITS-1:0] offset_t;   // Word offset inside a block

   localparam offset_t LAST_OFFSET = '1;

   logic          toggle_meta;   // Toggle synchroniser, first stage
   logic          toggle_sync;   // Toggle in the read domain
   logic          toggle_prev;   // For edge detection
   logic          done_edge;     // One cycle per completed block
   reader_state_t state;
   offset_t       offset;        // Offset being addressed
   logic          read_half;     // Half being swept

   // ------------------------------------------------------------------
   // Done toggle crossing
   // ------------------------------------------------------------------
   always_ff @(posedge read_clock_i) begin
      if (rst_i) begin
         toggle_meta <= 1'b0;
         toggle_sync <= 1'b0;
         toggle_prev <= 1'b0;
      end else begin
         toggle_meta <= done_toggle_i;
         toggle_sync <= toggle_meta;
         toggle_prev <= toggle_sync;
      end
   end

   // Either direction of the toggle means one more block
   assign done_edge = toggle_sync ^ toggle_prev;

   // ------------------------------------------------------------------
   // Address sequencer
   // ------------------------------------------------------------------
   always_ff @(posedge read_clock_i) begin
      if (rst_i) begin
         state     <= IDLE;
         offset    <= '0;
         read_half <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (done_edge) begin
                  state     <= STREAM;
                  read_half <= done_half_i;   // Settled well before the edge
                  offset    <= '0;
               end
            end
            STREAM: begin
               offset <= offset + 1'b1;   // One address per cycle
               if (offset == LAST_OFFSET) begin
                  state <= IDLE;           // Half fully swept
               end
            end
         endcase
      end
   end

   assign read_address_o = {read_half, offset};

   // ------------------------------------------------------------------
   // Output flags
   // ------------------------------------------------------------------
   // Valid trails the address by the one cycle of the RAM register
   always_ff @(posedge read_clock_i) begin
      if (rst_i) begin
         data_valid_o  <= 1'b0;
         block_start_o <= 1'b0;
         overflow_o    <= 1'b0;
      end else begin
         data_valid_o  <= (state == STREAM);
         block_start_o <= (state == STREAM) && (offset == '0);
         // Reader still busy with the previous block
         // The new block is never swept and is lost
         if (done_edge && (state == STREAM)) begin
            overflow_o <= 1'b1;
         end
      end
   end

   // Word comes straight from the buffer output register
   assign data_o = read_data_i;

endmodule

//--- hdl/acquire_top.sv
// Acquisition front end
// Sample domain capture, ping-pong buffer and read domain streamer
module acquire_top #(
   parameter int BLOCK_BITS = acq_ctrl_pkg::BLOCK_BITS_DEFAULT
) (
   input  logic                  read_clock_i,
   input  logic                  rst_i,          // Synchronous to read_clock_i
   input  logic                  write_clock_i,  // Sample clock
   input  logic                  acq_en_i,       // Read domain level
   input  acq_data_pkg::sample_t sample_i,       // Sample domain
   output acq_data_pkg::sample_t data_o,
   output logic                  data_valid_o,
   output logic                  block_start_o,
   output logic                  overflow_o
);
   import acq_data_pkg::*;

   logic                done_toggle;    // Crosses to the read domain
   logic                done_half;      // Half of the completed block
   logic [BLOCK_BITS:0] read_address;
   sample_t             read_data;

   // ------------------------------------------------------------------
   // Sample domain
   // ------------------------------------------------------------------
   buffer_write_if #(.BLOCK_BITS(BLOCK_BITS)) wr_bus (
      .write_clock (write_clock_i)
   );

   sample_capture #(.BLOCK_BITS(BLOCK_BITS)) capture_i (
      .wr            (wr_bus.writer),
      .rst_i         (rst_i),
      .acq_en_i      (acq_en_i),
      .sample_i      (sample_i),
      .done_toggle_o (done_toggle),
      .done_half_o   (done_half)
   );

   // Dual-clock storage between the domains
   block_buffer #(.BLOCK_BITS(BLOCK_BITS)) buffer_i (
      .ram            (wr_bus.ram),
      .read_clock_i   (read_clock_i),
      .read_address_i (read_address),
      .read_data_o    (read_data)
   );

   // ------------------------------------------------------------------
   // Read domain
   // ------------------------------------------------------------------
   block_reader #(.BLOCK_BITS(BLOCK_BITS)) reader_i (
      .read_clock_i   (read_clock_i),
      .rst_i          (rst_i),
      .done_toggle_i  (done_toggle),
      .done_half_i    (done_half),
      .read_address_o (read_address),
      .read_data_i    (read_data),
      .data_o         (data_o),
      .data_valid_o   (data_valid_o),
      .block_start_o  (block_start_o),
      .overflow_o     (overflow_o)
   );

endmodule

//--- bench/block_reader_checker.sv
// Output protocol assertions for the block reader
module block_reader_checker #(
   parameter int BLOCK_BITS = acq_ctrl_pkg::BLOCK_BITS_DEFAULT
) (
   input logic                        read_clock_i,
   input logic                        rst_i,
   input acq_ctrl_pkg::reader_state_t state_i,
   input logic                        data_valid_i,
   input logic                        block_start_i,
   input logic                        overflow_i
);
   timeunit 1ns;
   timeprecision 100ps;
   import acq_ctrl_pkg::*;

   localparam int BLOCK_WORDS = 2 ** BLOCK_BITS;

   int run_len;   // Valid words seen so far in the current run

   always_ff @(posedge read_clock_i) begin
      if (rst_i || !data_valid_i) begin
         run_len <= 0;
      end else begin
         run_len <= run_len + 1;
      end
   end

   // ------------------------------------------------------------------
   // Run framing
   // ------------------------------------------------------------------
   run_length_a: assert property (@(posedge read_clock_i) disable iff (rst_i)
      (!data_valid_i && run_len != 0) |-> run_len == BLOCK_WORDS)
      else $error("Valid run ended after %0d words", run_len);

   run_limit_a: assert property (@(posedge read_clock_i) disable iff (rst_i)
      data_valid_i |-> run_len < BLOCK_WORDS)
      else $error("Valid run longer than one block");

   // Start strobe marks the first word and only that one
   start_first_a: assert property (@(posedge read_clock_i) disable iff (rst_i)
      block_start_i |-> (data_valid_i && run_len == 0))
      else $error("Block start away from the first valid word");

   first_start_a: assert property (@(posedge read_clock_i) disable iff (rst_i)
      (data_valid_i && run_len == 0) |-> block_start_i)
      else $error("First valid word without block start");

   // ------------------------------------------------------------------
   // State and sticky flag
   // ------------------------------------------------------------------
   overflow_sticky_a: assert property (@(posedge read_clock_i)
      $fell(overflow_i) |-> $past(rst_i))
      else $error("Overflow flag cleared without reset");

   // Valid seen in IDLE is only the tail word of a finished sweep
   valid_from_stream_a: assert property (@(posedge read_clock_i) disable iff (rst_i)
      (data_valid_i && state_i == IDLE) |-> run_len == BLOCK_WORDS - 1)
      else $error("Valid output in IDLE that does not end a full sweep");

endmodule

bind block_reader block_reader_checker #(.BLOCK_BITS(BLOCK_BITS)) reader_checker_i (
   .read_clock_i  (read_clock_i),
   .rst_i         (rst_i),
   .state_i       (state),
   .data_valid_i  (data_valid_o),
   .block_start_i (block_start_o),
   .overflow_i    (overflow_o)
);

//--- bench/acquire_tb.sv
// Directed testbench for the acquisition front end
module acquire_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import acq_data_pkg::*;
   import acq_ctrl_pkg::*;

   localparam int BLOCK_BITS      = BLOCK_BITS_DEFAULT;
   localparam int BLOCK_WORDS     = 2 ** BLOCK_BITS;
   localparam int RESET_CYCLES    = 16;
   localparam int READ_PERIOD_NS  = 40;
   localparam int WRITE_HALF_NS   = 50;   // Default sample clock, 100 ns period
   // Blocks complete while the reader is busy,
   // yet the capture never laps the reader inside one half
   localparam int FAST_HALF_NS    = 15;
   localparam int TEST_BLOCKS     = 2 + 3 + 10 + 8 + 6;   // Budget per test, in order
   localparam int WATCHDOG_NS     = TEST_BLOCKS * BLOCK_WORDS * 2 * WRITE_HALF_NS * 4
                                    + RESET_CYCLES * READ_PERIOD_NS;

   logic    read_clock_i;
   logic    write_clock_i;
   logic    rst_i;
   logic    acq_en_i;
   sample_t sample_i;
   sample_t data_o;
   logic    data_valid_o;
   logic    block_start_o;
   logic    overflow_o;

   int          write_half_ns = WRITE_HALF_NS;
   logic [31:0] rng_state     = 32'd29101;
   sample_t     history[$];          // Every value driven on sample_i
   sample_t     got_words[$];        // Words of complete output blocks only
   int          run_len       = 0;   // Words of the run in progress
   int          blocks_seen   = 0;
   int          hist_from     = 0;   // History index after the last verified block
   int          checks        = 0;
   int          errors        = 0;

   acquire_top #(.BLOCK_BITS(BLOCK_BITS)) dut_i (
      .read_clock_i  (read_clock_i),
      .rst_i         (rst_i),
      .write_clock_i (write_clock_i),
      .acq_en_i      (acq_en_i),
      .sample_i      (sample_i),
      .data_o        (data_o),
      .data_valid_o  (data_valid_o),
      .block_start_o (block_start_o),
      .overflow_o    (overflow_o)
   );

   // ------------------------------------------------------------------
   // Clocks, stimulus and output monitor
   // ------------------------------------------------------------------
   initial begin
      read_clock_i = 1'b0;
      forever begin
         #(READ_PERIOD_NS / 2) read_clock_i = ~read_clock_i;
      end
   end

   initial begin
      write_clock_i = 1'b0;
      forever begin
         #(write_half_ns) write_clock_i = ~write_clock_i;   // Half period can change
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // New sample every write cycle, kept for the block checks
   always @(negedge write_clock_i) begin
      rng_state = xorshift32(rng_state);
      sample_i  = rng_state[SAMPLE_WIDTH-1:0];
      history.push_back(sample_i);
   end

   task automatic discard_run();
      repeat (run_len) void'(got_words.pop_back());   // Keep block indexing aligned
      run_len = 0;
   endtask

   // Outputs are stable on the falling read edge
   always @(negedge read_clock_i) begin
      if (data_valid_o) begin
         // Start strobe belongs on the first word of a run only
         check_flag("block_start_o", block_start_o, run_len == 0);
         if (block_start_o && run_len != 0) begin
            discard_run();   // Unfinished run dropped, a new one begins here
         end
         got_words.push_back(data_o);
         run_len++;
         if (run_len == BLOCK_WORDS) begin
            blocks_seen++;
            run_len = 0;
         end
      end else begin
         check_flag("block_start_o", block_start_o, 1'b0);   // Never without data
         if (run_len != 0) begin
            errors++;
            $display("Run ended after %0d of %0d words", run_len, BLOCK_WORDS);
            discard_run();
         end
      end
   end

   // ------------------------------------------------------------------
   // Helpers and compare tasks
   // ------------------------------------------------------------------
   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic apply_reset();
      @(negedge read_clock_i);
      rst_i = 1'b1;
      repeat (RESET_CYCLES) @(negedge read_clock_i);
      rst_i = 1'b0;
   endtask

   task automatic set_enable(input logic value);
      @(negedge read_clock_i);
      acq_en_i = value;
   endtask

   // Block count is updated on the falling edge, read it on the rising one
   task automatic wait_blocks(input int target);
      int limit;
      int cycles;
      limit  = (target - blocks_seen + 2) * BLOCK_WORDS * 8;
      cycles = 0;
      while (blocks_seen < target && cycles < limit) begin
         @(posedge read_clock_i);
         cycles++;
      end
      if (blocks_seen < target) begin
         errors++;
         $display("No block %0d after %0d read cycles", target, cycles);
      end
   endtask

   // Capture may finish one more block, then the reader empties it
   task automatic drain();
      repeat (BLOCK_WORDS + 4) @(posedge write_clock_i);
      repeat (BLOCK_WORDS + 8) @(posedge read_clock_i);
   endtask

   function automatic int find_in_history(input sample_t word, input int from);
      for (int i = from; i < history.size(); i++) begin
         if (history[i] == word) begin
            return i;
         end
      end
      return -1;
   endfunction

   // Each block must be a consecutive stretch of the history
   task automatic verify_blocks(input int first_b, input bit contiguous, output int gaps);
      int start;
      gaps = 0;
      for (int b = first_b; b < blocks_seen; b++) begin
         if (contiguous && b > first_b) begin
            start = hist_from;   // Must follow the previous block directly
         end else begin
            start = find_in_history(got_words[b * BLOCK_WORDS], hist_from);
         end
         if (start < 0 || start + BLOCK_WORDS > history.size()) begin
            errors++;
            $display("Block %0d matches no stretch of the sample history", b);
         end else begin
            if (b > first_b && start > hist_from) begin
               gaps++;
            end
            for (int k = 0; k < BLOCK_WORDS; k++) begin
               check_sample("data_o", got_words[b * BLOCK_WORDS + k], history[start + k]);
            end
            hist_from = start + BLOCK_WORDS;
         end
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d error(s)", name, errors - errors_before);
      end
   endtask

   // ------------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------------
   task automatic quiet_after_reset();
      int err0;
      err0 = errors;
      repeat (200) begin
         @(negedge read_clock_i);
         check_flag("data_valid_o", data_valid_o, 1'b0);
         check_flag("block_start_o", block_start_o, 1'b0);
         check_flag("overflow_o", overflow_o, 1'b0);
      end
      report_test("reset_state", err0);
   endtask

   task automatic single_block();
      int err0;
      int first_b;
      int gaps;
      err0    = errors;
      first_b = blocks_seen;
      set_enable(1'b1);
      wait_blocks(first_b + 1);
      set_enable(1'b0);
      drain();
      verify_blocks(first_b, 1'b0, gaps);
      report_test("single_block", err0);
   endtask

   task automatic continuous_capture();
      int err0;
      int first_b;
      int gaps;
      err0    = errors;
      first_b = blocks_seen;
      set_enable(1'b1);
      wait_blocks(first_b + 8);
      set_enable(1'b0);
      drain();
      verify_blocks(first_b, 1'b1, gaps);
      @(negedge read_clock_i);
      check_flag("overflow_o", overflow_o, 1'b0);
      report_test("continuous", err0);
   endtask

   task automatic stop_on_boundary();
      int err0;
      int first_b;
      int stop_b;
      int end_b;
      int gaps;
      err0    = errors;
      first_b = blocks_seen;
      set_enable(1'b1);
      wait_blocks(first_b + 1);
      repeat (2) @(posedge write_clock_i);   // Capture is now inside a block
      set_enable(1'b0);
      stop_b = blocks_seen;
      drain();
      end_b = blocks_seen;
      // The block being filled at the stop still comes out whole
      if (end_b <= stop_b) begin
         errors++;
         $display("Block in progress when capture stopped was never delivered");
      end
      repeat (4 * BLOCK_WORDS) @(posedge write_clock_i);
      if (blocks_seen != end_b || run_len != 0) begin
         errors++;
         $display("Output continued after capture stopped on a boundary");
      end
      verify_blocks(first_b, 1'b1, gaps);
      report_test("stop_on_boundary", err0);
   endtask

   task automatic overflow_drop();
      int err0;
      int first_b;
      int gaps;
      err0          = errors;
      write_half_ns = FAST_HALF_NS;
      apply_reset();
      @(negedge read_clock_i);
      check_flag("overflow_o", overflow_o, 1'b0);
      first_b = blocks_seen;
      set_enable(1'b1);
      wait_blocks(first_b + 4);
      @(negedge read_clock_i);
      check_flag("overflow_o", overflow_o, 1'b1);
      set_enable(1'b0);
      drain();
      verify_blocks(first_b, 1'b0, gaps);
      @(negedge read_clock_i);
      check_flag("overflow_o", overflow_o, 1'b1);   // Still set
      if (gaps == 0) begin
         errors++;
         $display("No samples were skipped between delivered blocks");
      end
      report_test("overflow", err0);
   endtask

   // ------------------------------------------------------------------
   // Sequence and watchdog
   // ------------------------------------------------------------------
   initial begin
      rst_i    = 1'b1;
      acq_en_i = 1'b0;
      sample_i = '0;
      apply_reset();
      quiet_after_reset();
      single_block();
      continuous_capture();
      stop_on_boundary();
      overflow_drop();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

//--- src.f
hdl/acq_data_pkg.sv
hdl/acq_ctrl_pkg.sv
hdl/buffer_write_if.sv
hdl/block_buffer.sv
hdl/sample_capture.sv
hdl/block_reader.sv
hdl/acquire_top.sv
bench/block_reader_checker.sv
bench/acquire_tb.sv

//--- Makefile
# Verilator build and run of the acquisition testbench

VERILATOR ?= verilator
TOP       ?= acquire_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
